// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := burst_buffer_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "TESTBENCH FAILED" $(SIM_LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(SIM_LOG) || (echo "simulation ended early"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== bench/burst_buffer_properties.sv ====
`timescale 1ns/1ps
`include "burst_macros.svh"

module burst_buffer_properties (
    input logic             clk,
    input logic             reset,
    input logic             in_req,
    input logic             in_ack,
    input logic             out_req,
    input burst_pkg::word_t out_data,
    input logic             out_last
);

    import burst_pkg::*;

    // Producer side of the input handshake
    req_after_ack_low: assert property (
        @(posedge clk) disable iff (reset) $rose(in_req) |-> !in_ack
    ) else $error("in_req rose while in_ack was still high");

    // Payload held for the whole output request
    out_payload_stable: assert property (
        @(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> ($stable(out_data) && $stable(out_last))
    ) else $error("out_data or out_last changed while out_req was high");

    out_req_quiet_in_reset: assert property (
        @(posedge clk) (reset || $past(reset)) |-> !out_req
    ) else $error("out_req high during reset or the cycle after");

endmodule

// ==== bench/burst_buffer_tb.sv ====
`timescale 1ns/1ps
`include "burst_macros.svh"

module burst_buffer_tb;

    import burst_pkg::*;

    localparam int TOTAL_WORDS  = 12 + 6 + 24 + 100;
    localparam int LIMIT_CYCLES = 200 * TOTAL_WORDS + 1000;

    logic  clk;
    logic  reset;
    logic  flush;
    logic  in_req;
    word_t in_data;
    logic  in_ack;
    logic  out_req;
    word_t out_data;
    logic  out_last;
    logic  out_ack;

    logic [31:0] rng_state = 32'hdffe_c63f;
    word_t       exp_data_q[$];
    logic        exp_last_q[$];
    int          open_cnt;
    int          accepted;
    int          outputs;
    int          errors;
    int          test_errors;
    logic        stall;

    burst_buffer_top dut_i (.*);

    bind burst_buffer_top burst_buffer_properties props_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Outputs are registered, so they have settled 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_word(input word_t data);
        open_cnt++;
        exp_data_q.push_back(data);
        exp_last_q.push_back(open_cnt == `BURST_LEN);
        if (open_cnt == `BURST_LEN) begin
            open_cnt = 0;
        end
        in_data = data;
        in_req  = 1'b1;
        tick();
        while (!in_ack) tick();
        accepted++;
        in_req = 1'b0;
        tick();
        while (in_ack) tick();
    endtask

    // Closes the open burst on the word sent last
    task automatic flush_burst();
        if (open_cnt != 0) begin
            exp_last_q[exp_last_q.size() - 1] = 1'b1;
            open_cnt = 0;
        end
        flush = 1'b1;
        tick();
        flush = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data_q.size() != 0) tick();
        repeat (5) tick();
    endtask

    task automatic check_output(input word_t data, input logic last);
        word_t exp_data;
        logic  exp_last;
        // Every completed transfer counts, expected or not
        outputs++;
        assert (exp_data_q.size() != 0) else begin
            $display("output word %h at %0t arrived with no word left to send", data, $time);
            errors++;
        end
        if (exp_data_q.size() != 0) begin
            exp_data = exp_data_q.pop_front();
            exp_last = exp_last_q.pop_front();
            assert (data == exp_data && last == exp_last) else begin
                $display("mismatch at %0t: got %h last %b, expected %h last %b",
                         $time, data, last, exp_data, exp_last);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Consumer with random ack delay
    initial begin : consumer
        word_t got_data;
        logic  got_last;
        out_ack = 1'b0;
        forever begin
            tick();
            if (out_req) begin
                got_data = out_data;
                got_last = out_last;
                while (stall) tick();
                repeat (next_rand() % 6) tick();
                out_ack = 1'b1;
                tick();
                while (out_req) tick();
                out_ack = 1'b0;
                check_output(got_data, got_last);
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", LIMIT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        int base;
        reset   = 1'b1;
        flush   = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        stall   = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        repeat (20) tick();
        assert (!out_req && !in_ack && outputs == 0) else begin
            $display("output side active at %0t with no input sent", $time);
            errors++;
        end
        report_test("reset");

        repeat (12) send_word(word_t'(next_rand()));
        wait_drained();
        report_test("full_bursts");

        repeat (6) send_word(word_t'(next_rand()));
        flush_burst();
        wait_drained();
        base = outputs;
        flush_burst();
        repeat (30) tick();
        assert (outputs == base) else begin
            $display("flush with no open burst produced output at %0t", $time);
            errors++;
        end
        report_test("flush");

        // FIFOs plus the sender hold at most one data FIFO's worth and one word
        stall = 1'b1;
        base  = accepted;
        fork
            repeat (24) send_word(word_t'(next_rand()));
            begin
                repeat (60) tick();
                assert (accepted - base <= `BURST_DATA_DEPTH + 1 && in_req && !in_ack)
                else begin
                    $display("input kept being acked during a stalled output at %0t", $time);
                    errors++;
                end
                stall = 1'b0;
            end
        join
        wait_drained();
        report_test("backpressure");

        repeat (100) begin
            repeat (next_rand() % 4) tick();
            send_word(word_t'(next_rand()));
            if (next_rand() % 8 == 0) begin
                flush_burst();
            end
        end
        flush_burst();
        wait_drained();
        report_test("random_mix");

        $display("summary: %0d words checked, %0d errors", outputs, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/burst_pkg.sv
rtl/sync_fifo.sv
rtl/word_rx_port.sv
rtl/word_tx_port.sv
rtl/burst_ctrl.sv
rtl/burst_buffer_top.sv
bench/burst_buffer_properties.sv
bench/burst_buffer_tb.sv

// ==== rtl/burst_buffer_top.sv ====
`timescale 1ns/1ps
`include "burst_macros.svh"

module burst_buffer_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             in_req,
    input  burst_pkg::word_t in_data,
    output logic             in_ack,
    output logic             out_req,
    output burst_pkg::word_t out_data,
    output logic             out_last,
    input  logic             out_ack
);

    import burst_pkg::*;

    logic  rx_valid;
    word_t rx_word;
    logic  rx_take;
    logic  dat_wr_en;
    logic  dat_full;
    logic  dat_rd_en;
    word_t dat_rd_data;
    logic  desc_wr_en;
    desc_t desc_wr_data;
    logic  desc_full;
    logic  desc_rd_en;
    desc_t desc_rd_data;
    logic  desc_empty;
    logic  tx_load;
    word_t tx_word;
    logic  tx_last;
    logic  tx_idle;

    word_rx_port rx_port_i (.*);

    burst_ctrl ctrl_i (.*);

    sync_fifo #(.payload_t(word_t), .DEPTH(`BURST_DATA_DEPTH)) data_fifo_i (
        .clk, .reset,
        .wr_en   (dat_wr_en),
        .wr_data (rx_word),
        .rd_en   (dat_rd_en),
        .rd_data (dat_rd_data),
        .full    (dat_full),
        .empty   ()
    );

    sync_fifo #(.payload_t(desc_t), .DEPTH(`BURST_DESC_DEPTH)) desc_fifo_i (
        .clk, .reset,
        .wr_en   (desc_wr_en),
        .wr_data (desc_wr_data),
        .rd_en   (desc_rd_en),
        .rd_data (desc_rd_data),
        .full    (desc_full),
        .empty   (desc_empty)
    );

    word_tx_port tx_port_i (.*);

endmodule

// ==== rtl/burst_ctrl.sv ====
`timescale 1ns/1ps
`include "burst_macros.svh"

module burst_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             rx_valid,
    output logic             rx_take,
    output logic             dat_wr_en,
    input  logic             dat_full,
    output logic             desc_wr_en,
    output burst_pkg::desc_t desc_wr_data,
    input  logic             desc_full,
    output logic             desc_rd_en,
    input  burst_pkg::desc_t desc_rd_data,
    input  logic             desc_empty,
    output logic             dat_rd_en,
    input  burst_pkg::word_t dat_rd_data,
    output logic             tx_load,
    output burst_pkg::word_t tx_word,
    output logic             tx_last,
    input  logic             tx_idle
);

    import burst_pkg::*;

    localparam len_t LEN_MAX = `BURST_LEN;

    typedef enum logic [1:0] {
        D_IDLE,
        D_DESC,
        D_READ,
        D_LOAD
    } drain_state_t;

    len_t         open_cnt;
    len_t         cnt_next;
    logic         close;
    len_t         remain;
    drain_state_t state;

    // Fill side
    assign rx_take   = rx_valid && !dat_full && !desc_full;
    assign dat_wr_en = rx_take;
    assign cnt_next  = open_cnt + len_t'(rx_take);
    // Same-cycle word and flush: word joins, then the burst closes
    assign close     = (rx_take && cnt_next == LEN_MAX) || (flush && cnt_next != '0);

    assign desc_wr_en       = close;
    assign desc_wr_data.len = cnt_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            open_cnt <= '0;
        end else begin
            open_cnt <= close ? '0 : cnt_next;
        end
    end

    // Drain side
    assign desc_rd_en = (state == D_IDLE) && !desc_empty;
    assign dat_rd_en  = (state == D_READ) && tx_idle;
    assign tx_load    = (state == D_LOAD);
    assign tx_word    = dat_rd_data;
    assign tx_last    = (remain == len_t'(1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= D_IDLE;
            remain <= '0;
        end else begin
            case (state)
                D_IDLE: if (desc_rd_en) state <= D_DESC;
                D_DESC: begin
                    remain <= desc_rd_data.len;
                    state  <= D_READ;
                end
                D_READ: if (dat_rd_en) state <= D_LOAD;
                D_LOAD: begin
                    remain <= remain - 1'b1;
                    state  <= tx_last ? D_IDLE : D_READ;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/burst_macros.svh ====
`ifndef BURST_MACROS_SVH
`define BURST_MACROS_SVH

// Data word width in bits
`define BURST_WORD_W 16

`define BURST_DATA_DEPTH 16
`define BURST_DESC_DEPTH 4

// Keep BURST_LEN at or below BURST_DATA_DEPTH
`define BURST_LEN 4
`define BURST_LEN_W 3

`endif

// ==== rtl/burst_pkg.sv ====
`include "burst_macros.svh"

package burst_pkg;

    // One data word as carried through the buffer
    typedef logic [`BURST_WORD_W-1:0] word_t;

    // Length of a closed burst
    typedef logic [`BURST_LEN_W-1:0] len_t;

    // Burst descriptor held in the descriptor FIFO
    typedef struct packed {
        len_t len;
    } desc_t;

endpackage

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count_q == FULL_CNT);
    assign empty = (count_q == '0);

    // A same-cycle read frees the slot a write needs when full,
    // and a same-cycle write feeds a read when empty
    assign do_wr = wr_en && (!full || rd_en);
    assign do_rd = rd_en && (!empty || wr_en);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            rd_data <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr  <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
                // Bypass when empty, memory slot not yet written
                rd_data <= empty ? wr_data : mem[rd_ptr];
            end else begin
                rd_data <= '0;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== rtl/word_rx_port.sv ====
`timescale 1ns/1ps

module word_rx_port (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_req,
    input  burst_pkg::word_t in_data,
    output logic            in_ack,
    output logic            rx_valid,
    output burst_pkg::word_t rx_word,
    input  logic            rx_take
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HOLD,
        RX_ACK
    } rx_state_t;

    rx_state_t state;

    assign rx_valid = (state == RX_HOLD);
    assign in_ack   = (state == RX_ACK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: if (in_req) state <= RX_HOLD;
                RX_HOLD: if (rx_take) state <= RX_ACK;
                // Wait for the producer to release its request
                RX_ACK:  if (!in_req) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Word is taken as the request is first seen
    always_ff @(posedge clk) begin
        if (state == RX_IDLE && in_req) begin
            rx_word <= in_data;
        end
    end

endmodule

// ==== rtl/word_tx_port.sv ====
`timescale 1ns/1ps

module word_tx_port (
    input  logic             clk,
    input  logic             reset,
    input  logic             tx_load,
    input  burst_pkg::word_t tx_word,
    input  logic             tx_last,
    output logic             tx_idle,
    output logic             out_req,
    output burst_pkg::word_t out_data,
    output logic             out_last,
    input  logic             out_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_DROP
    } tx_state_t;

    tx_state_t state;

    assign tx_idle = (state == TX_IDLE);
    assign out_req = (state == TX_REQ);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= TX_IDLE;
            out_last <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_load) begin
                        state    <= TX_REQ;
                        out_last <= tx_last;
                    end
                end
                TX_REQ:  if (out_ack) state <= TX_DROP;
                // Consumer still holds ack from this transfer
                TX_DROP: if (!out_ack) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_idle && tx_load) begin
            out_data <= tx_word;
        end
    end

endmodule
